//--- rtl/audio_pkt_pkg.sv
// shared types for the audio to UDP transmit bridge
// sample, word and byte count widths, packer output struct,
// scheduler state encoding

package audio_pkt_pkg;

    // one audio sample from the codec side
    typedef logic [15:0] sample_t;

    // two samples packed, earlier sample in [31:16]
    typedef logic [31:0] word_t;

    // payload byte count, same width as udp_tx_byte_num
    typedef logic [15:0] byte_cnt_t;

    // packer to FIFO write port
    typedef struct packed {
        logic  valid;   // one cycle per packed word
        word_t data;
    } audio_word_s;

    // packet scheduler FSM
    typedef enum logic [1:0] {
        idle      = 2'd0,   // waiting for a full packet in the FIFO
        start     = 2'd1,   // start pulse to the UDP core
        send      = 2'd2,   // answering requests
        wait_done = 2'd3    // all words handed over
    } pkt_state_e;

endpackage

//--- rtl/audio_sample_packer.sv
// audio sample packer, audio_clk domain
// gates samples by transfer_flag, packs two samples per word,
// flags a word lost to a full FIFO
`timescale 1ns/1ps

module audio_sample_packer (
    input  logic                        audio_clk,
    input  logic                        rst_n,
    input  logic                        audio_en,
    input  audio_pkt_pkg::sample_t      audio_data,
    input  logic                        transfer_flag,
    input  logic                        fifo_full,
    output audio_pkt_pkg::audio_word_s  wr_word,
    output logic                        fifo_overflow
);

    logic                   phase;        // high while a half word is held
    audio_pkt_pkg::sample_t half_sample;  // earlier sample of the pair
    logic                   word_valid;
    audio_pkt_pkg::word_t   word_data;
    logic                   sample_ok;
    logic                   pair_done;

    assign sample_ok = audio_en & transfer_flag;
    assign pair_done = sample_ok & phase;

    // control state
    always_ff @(posedge audio_clk or negedge rst_n) begin
        if (!rst_n) begin
            phase         <= 1'b0;
            word_valid    <= 1'b0;
            fifo_overflow <= 1'b0;
        end else begin
            word_valid <= 1'b0;
            if (!transfer_flag) begin
                phase <= 1'b0;  // drop any pending half word
            end else if (audio_en) begin
                phase <= ~phase;
                if (phase) begin
                    if (fifo_full)
                        fifo_overflow <= 1'b1;  // sticky until reset
                    else
                        word_valid <= 1'b1;
                end
            end
        end
    end

    // sample payload
    always_ff @(posedge audio_clk) begin
        if (sample_ok && !phase)
            half_sample <= audio_data;
        if (pair_done)
            word_data <= {half_sample, audio_data};  // earlier sample on top
    end

    assign wr_word = '{valid: word_valid, data: word_data};

endmodule

//--- rtl/audio_async_fifo.sv
// dual clock word FIFO
// Gray coded pointers with two flop synchronizers both ways,
// full on the write side, fill level on the read side
`timescale 1ns/1ps

module audio_async_fifo #(
    parameter int FIFO_ADDR_W = 6
) (
    // write side, audio_clk
    input  logic                        wr_clk,
    input  logic                        rst_n,
    input  audio_pkt_pkg::audio_word_s  wr_word,
    output logic                        full,
    // read side, eth_tx_clk
    input  logic                        rd_clk,
    input  logic                        rd_en,
    output audio_pkt_pkg::word_t        rd_data,
    output logic [FIFO_ADDR_W:0]        rd_level
);

    localparam int DEPTH = 2 ** FIFO_ADDR_W;

    audio_pkt_pkg::word_t mem [DEPTH];

    logic [FIFO_ADDR_W:0] wr_bin;
    logic [FIFO_ADDR_W:0] wr_bin_nxt;
    logic [FIFO_ADDR_W:0] wr_gray;
    logic [FIFO_ADDR_W:0] rd_bin;
    logic [FIFO_ADDR_W:0] rd_bin_nxt;
    logic [FIFO_ADDR_W:0] rd_gray;
    logic [FIFO_ADDR_W:0] rd_gray_s1;   // rd pointer into wr domain
    logic [FIFO_ADDR_W:0] rd_gray_s2;
    logic [FIFO_ADDR_W:0] wr_gray_s1;   // wr pointer into rd domain
    logic [FIFO_ADDR_W:0] wr_gray_s2;
    logic [FIFO_ADDR_W:0] wr_bin_sync;
    logic                 wr_fire;
    logic                 rd_fire;
    logic                 empty;

    function automatic logic [FIFO_ADDR_W:0] gray2bin(input logic [FIFO_ADDR_W:0] g);
        logic [FIFO_ADDR_W:0] b;
        b[FIFO_ADDR_W] = g[FIFO_ADDR_W];
        for (int i = FIFO_ADDR_W - 1; i >= 0; i--) begin
            b[i] = b[i+1] ^ g[i];
        end
        return b;
    endfunction

    // write domain
    assign wr_fire    = wr_word.valid & ~full;  // words meeting a full FIFO are dropped
    assign wr_bin_nxt = wr_bin + 1'b1;

    // full when the pointers differ only in the wrap bits
    assign full = (wr_gray == {~rd_gray_s2[FIFO_ADDR_W:FIFO_ADDR_W-1],
                               rd_gray_s2[FIFO_ADDR_W-2:0]});

    always_ff @(posedge wr_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_bin     <= '0;
            wr_gray    <= '0;
            rd_gray_s1 <= '0;
            rd_gray_s2 <= '0;
        end else begin
            rd_gray_s1 <= rd_gray;
            rd_gray_s2 <= rd_gray_s1;
            if (wr_fire) begin
                wr_bin  <= wr_bin_nxt;
                wr_gray <= wr_bin_nxt ^ (wr_bin_nxt >> 1);
            end
        end
    end

    always_ff @(posedge wr_clk) begin
        if (wr_fire)
            mem[wr_bin[FIFO_ADDR_W-1:0]] <= wr_word.data;
    end

    // read domain
    assign wr_bin_sync = gray2bin(wr_gray_s2);
    assign rd_level    = wr_bin_sync - rd_bin;  // lags writes by the sync delay
    assign empty       = (rd_level == '0);
    assign rd_fire     = rd_en & ~empty;
    assign rd_bin_nxt  = rd_bin + 1'b1;

    always_ff @(posedge rd_clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_bin     <= '0;
            rd_gray    <= '0;
            wr_gray_s1 <= '0;
            wr_gray_s2 <= '0;
            rd_data    <= '0;
        end else begin
            wr_gray_s1 <= wr_gray;
            wr_gray_s2 <= wr_gray_s1;
            if (rd_fire) begin
                rd_data <= mem[rd_bin[FIFO_ADDR_W-1:0]];  // one cycle after rd_en
                rd_bin  <= rd_bin_nxt;
                rd_gray <= rd_bin_nxt ^ (rd_bin_nxt >> 1);
            end
        end
    end

endmodule

//--- rtl/udp_pkt_scheduler.sv
// UDP packet scheduler, eth_tx_clk domain
// starts a packet once a whole packet is buffered, pops one word
// per core request, then waits for the core's done pulse
`timescale 1ns/1ps

module udp_pkt_scheduler #(
    parameter int PKT_WORDS   = 16,
    parameter int FIFO_ADDR_W = 6
) (
    input  logic                       eth_tx_clk,
    input  logic                       rst_n,
    input  logic [FIFO_ADDR_W:0]       rd_level,
    input  audio_pkt_pkg::word_t       rd_data,
    input  logic                       udp_tx_req,
    input  logic                       udp_tx_done,
    output logic                       rd_en,
    output logic                       udp_tx_start_en,
    output audio_pkt_pkg::word_t       udp_tx_data,
    output audio_pkt_pkg::byte_cnt_t   udp_tx_byte_num
);

    localparam int CNT_W = $clog2(PKT_WORDS + 1);

    audio_pkt_pkg::pkt_state_e state;
    audio_pkt_pkg::pkt_state_e state_nxt;
    logic [CNT_W-1:0]          word_cnt;   // words popped in this packet
    logic                      pkt_ready;
    logic                      last_word;

    assign pkt_ready = (rd_level >= (FIFO_ADDR_W + 1)'(PKT_WORDS));

    // requests past the packet length are ignored
    assign rd_en = udp_tx_req && (state == audio_pkt_pkg::send) &&
                   (word_cnt < CNT_W'(PKT_WORDS));

    assign last_word = rd_en && (word_cnt == CNT_W'(PKT_WORDS - 1));

    always_comb begin
        state_nxt = state;
        case (state)
            audio_pkt_pkg::idle: begin
                if (pkt_ready)
                    state_nxt = audio_pkt_pkg::start;
            end
            audio_pkt_pkg::start: begin
                state_nxt = audio_pkt_pkg::send;
            end
            audio_pkt_pkg::send: begin
                if (last_word)
                    state_nxt = audio_pkt_pkg::wait_done;
            end
            audio_pkt_pkg::wait_done: begin
                if (udp_tx_done)
                    state_nxt = audio_pkt_pkg::idle;
            end
            default: state_nxt = audio_pkt_pkg::idle;
        endcase
    end

    always_ff @(posedge eth_tx_clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= audio_pkt_pkg::idle;
            word_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (state == audio_pkt_pkg::idle)
                word_cnt <= '0;
            else if (rd_en)
                word_cnt <= word_cnt + 1'b1;
        end
    end

    // one cycle pulse, the cycle after leaving idle
    assign udp_tx_start_en = (state == audio_pkt_pkg::start);

    // FIFO read register holds the last popped word
    assign udp_tx_data = rd_data;

    assign udp_tx_byte_num = audio_pkt_pkg::byte_cnt_t'(PKT_WORDS * 4);

endmodule

//--- rtl/audio_udp_tx_top.sv
// audio to UDP transmit bridge, top level
// sample packer (audio_clk) -> async FIFO -> packet scheduler (eth_tx_clk)
`timescale 1ns/1ps

module audio_udp_tx_top #(
    parameter int PKT_WORDS   = 16,  // words per UDP packet
    parameter int FIFO_ADDR_W = 6    // 64 word FIFO
) (
    input  logic                      rst_n,
    // audio side
    input  logic                      audio_clk,
    input  logic                      audio_en,
    input  audio_pkt_pkg::sample_t    audio_data,
    input  logic                      transfer_flag,
    output logic                      fifo_overflow,
    // ethernet side
    input  logic                      eth_tx_clk,
    input  logic                      udp_tx_req,
    input  logic                      udp_tx_done,
    output logic                      udp_tx_start_en,
    output audio_pkt_pkg::word_t      udp_tx_data,
    output audio_pkt_pkg::byte_cnt_t  udp_tx_byte_num
);

    audio_pkt_pkg::audio_word_s wr_word;
    logic                       fifo_full;
    logic                       rd_en;
    audio_pkt_pkg::word_t       rd_data;
    logic [FIFO_ADDR_W:0]       rd_level;

    audio_sample_packer u_packer (
        .audio_clk     (audio_clk),
        .rst_n         (rst_n),
        .audio_en      (audio_en),
        .audio_data    (audio_data),
        .transfer_flag (transfer_flag),
        .fifo_full     (fifo_full),
        .wr_word       (wr_word),
        .fifo_overflow (fifo_overflow)
    );

    audio_async_fifo #(
        .FIFO_ADDR_W (FIFO_ADDR_W)
    ) u_fifo (
        .wr_clk   (audio_clk),
        .rst_n    (rst_n),
        .wr_word  (wr_word),
        .full     (fifo_full),
        .rd_clk   (eth_tx_clk),
        .rd_en    (rd_en),
        .rd_data  (rd_data),
        .rd_level (rd_level)
    );

    udp_pkt_scheduler #(
        .PKT_WORDS   (PKT_WORDS),
        .FIFO_ADDR_W (FIFO_ADDR_W)
    ) u_sched (
        .eth_tx_clk      (eth_tx_clk),
        .rst_n           (rst_n),
        .rd_level        (rd_level),   // packet threshold checked here
        .rd_data         (rd_data),
        .udp_tx_req      (udp_tx_req),
        .udp_tx_done     (udp_tx_done),
        .rd_en           (rd_en),
        .udp_tx_start_en (udp_tx_start_en),
        .udp_tx_data     (udp_tx_data),
        .udp_tx_byte_num (udp_tx_byte_num)
    );

endmodule

//--- sim/audio_udp_tx_checker.sv
// concurrent assertions on the bridge top level ports
// start pulse width, fixed byte count, outputs after reset
`timescale 1ns/1ps

module audio_udp_tx_checker #(
    parameter int PKT_WORDS = 16
) (
    input logic                     audio_clk,
    input logic                     eth_tx_clk,
    input logic                     rst_n,
    input logic                     fifo_overflow,
    input logic                     udp_tx_start_en,
    input audio_pkt_pkg::byte_cnt_t udp_tx_byte_num
);

    // start is a single cycle pulse
    start_one_cycle: assert property (@(posedge eth_tx_clk) disable iff (!rst_n)
        udp_tx_start_en |=> !udp_tx_start_en)
        else $error("udp_tx_start_en high for two cycles in a row");

    byte_num_fixed: assert property (@(posedge eth_tx_clk) disable iff (!rst_n)
        udp_tx_byte_num == audio_pkt_pkg::byte_cnt_t'(PKT_WORDS * 4))
        else $error("udp_tx_byte_num differs from the packet size");

    quiet_after_reset: assert property (@(posedge audio_clk)
        $rose(rst_n) |-> (!fifo_overflow && !udp_tx_start_en))
        else $error("start or overflow set right after reset");

endmodule

bind audio_udp_tx_top audio_udp_tx_checker #(
    .PKT_WORDS (PKT_WORDS)
) u_checker (
    .audio_clk       (audio_clk),
    .eth_tx_clk      (eth_tx_clk),
    .rst_n           (rst_n),
    .fifo_overflow   (fifo_overflow),
    .udp_tx_start_en (udp_tx_start_en),
    .udp_tx_byte_num (udp_tx_byte_num)
);

//--- sim/tb_audio_udp_tx.sv
// testbench for the audio to UDP transmit bridge
// random audio stimulus, UDP core model, reference word queue and checks
`timescale 1ns/1ps

module tb_audio_udp_tx;

    localparam int PKT_WORDS   = 16;
    localparam int FIFO_ADDR_W = 6;
    localparam int DEPTH       = 2 ** FIFO_ADDR_W;
    localparam int WAIT_LIMIT  = 20000;  // clock cycles per wait loop

    logic                     audio_clk       = 1'b0;
    logic                     eth_tx_clk      = 1'b0;
    logic                     rst_n           = 1'b0;
    logic                     audio_en        = 1'b0;
    audio_pkt_pkg::sample_t   audio_data      = '0;
    logic                     transfer_flag   = 1'b0;
    logic                     udp_tx_req      = 1'b0;
    logic                     udp_tx_done     = 1'b0;
    logic                     fifo_overflow;
    logic                     udp_tx_start_en;
    audio_pkt_pkg::word_t     udp_tx_data;
    audio_pkt_pkg::byte_cnt_t udp_tx_byte_num;

    // reference model
    audio_pkt_pkg::word_t   exp_q[$];
    audio_pkt_pkg::sample_t model_half;
    bit                     model_phase = 1'b0;
    int pushed   = 0;   // words the model expects out of the FIFO
    int dropped  = 0;   // words lost to a full FIFO
    int popped   = 0;   // requests issued by the core model
    int captured = 0;
    int packets  = 0;
    int low_left = 0;   // remaining cycles of a transfer_flag low stretch
    bit in_pkt   = 1'b0;
    bit stim_on  = 1'b0;
    bit hold_req = 1'b0;  // core stops requesting while set
    bit run_done = 1'b0;
    int checks   = 0;
    int errors   = 0;
    int timeouts = 0;

    audio_udp_tx_top #(
        .PKT_WORDS   (PKT_WORDS),
        .FIFO_ADDR_W (FIFO_ADDR_W)
    ) u_dut (
        .rst_n           (rst_n),
        .audio_clk       (audio_clk),
        .audio_en        (audio_en),
        .audio_data      (audio_data),
        .transfer_flag   (transfer_flag),
        .fifo_overflow   (fifo_overflow),
        .eth_tx_clk      (eth_tx_clk),
        .udp_tx_req      (udp_tx_req),
        .udp_tx_done     (udp_tx_done),
        .udp_tx_start_en (udp_tx_start_en),
        .udp_tx_data     (udp_tx_data),
        .udp_tx_byte_num (udp_tx_byte_num)
    );

    initial begin
        forever #2 audio_clk = ~audio_clk;
    end

    initial begin
        forever #1 eth_tx_clk = ~eth_tx_clk;
    end

    task automatic check_equal(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("ERROR at %0t ns: %s, got %h expected %h", $time, what, got, expected);
        end
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("Timeout at %0t ns: gave up waiting for %s", $time, what);
    endtask

    // pairs accepted samples with the earlier one on top
    task automatic model_sample();
        if (!transfer_flag) begin
            model_phase = 1'b0;  // half pair lost
        end else if (audio_en) begin
            if (!model_phase) begin
                model_half  = audio_data;
                model_phase = 1'b1;
            end else begin
                model_phase = 1'b0;
                if (pushed - popped >= DEPTH) begin
                    dropped++;  // word lost to a full FIFO
                end else begin
                    exp_q.push_back({model_half, audio_data});
                    pushed++;
                end
            end
        end
    endtask

    // model runs on the same input values the DUT samples on this edge
    always @(posedge audio_clk) begin
        if (rst_n)
            model_sample();
        if (low_left > 0) begin
            low_left--;
            transfer_flag <= 1'b0;
        end else if ($urandom_range(199) == 0) begin
            low_left = $urandom_range(20, 5);
            transfer_flag <= 1'b0;
        end else begin
            transfer_flag <= 1'b1;
        end
        if (stim_on) begin
            audio_en   <= ($urandom_range(2) == 0);  // about one in three
            audio_data <= audio_pkt_pkg::sample_t'($urandom);
        end else begin
            audio_en <= 1'b0;
        end
    end

    // packet framing monitor
    always @(posedge eth_tx_clk) begin
        if (rst_n) begin
            if (udp_tx_start_en) begin
                check_equal(32'(in_pkt), 0, "start pulse inside an open packet");
                check_equal(32'(udp_tx_byte_num), PKT_WORDS * 4, "udp_tx_byte_num");
                in_pkt = 1'b1;
                packets++;
            end
            if (udp_tx_done)
                in_pkt = 1'b0;
        end
    end

    // UDP core model with one request per word
    initial begin : udp_core_model
        int wait_cnt;
        audio_pkt_pkg::word_t got;
        audio_pkt_pkg::word_t last_exp;
        last_exp = '0;
        while (!run_done) begin
            wait_cnt = 0;
            @(posedge eth_tx_clk);
            while (!udp_tx_start_en && !run_done && wait_cnt < WAIT_LIMIT) begin
                @(posedge eth_tx_clk);
                wait_cnt++;
            end
            if (!udp_tx_start_en) begin
                if (!run_done)
                    report_timeout("udp_tx_start_en");
                break;
            end
            for (int w = 0; w < PKT_WORDS; w++) begin
                repeat ($urandom_range(3)) @(posedge eth_tx_clk);
                wait_cnt = 0;
                while (hold_req && wait_cnt < WAIT_LIMIT) begin
                    @(posedge eth_tx_clk);
                    wait_cnt++;
                end
                if (hold_req)
                    report_timeout("release of the request hold");
                udp_tx_req <= 1'b1;
                popped++;
                @(posedge eth_tx_clk);
                udp_tx_req <= 1'b0;
                @(posedge eth_tx_clk);
                got = udp_tx_data;  // data valid the cycle after the request
                check_equal(32'(exp_q.size() != 0), 1, "expected word available");
                if (exp_q.size() != 0) begin
                    last_exp = exp_q.pop_front();
                    check_equal(got, last_exp, "packet word");
                end
                captured++;
            end
            // a request past the packet end must not pop
            udp_tx_req <= 1'b1;
            @(posedge eth_tx_clk);
            udp_tx_req <= 1'b0;
            @(posedge eth_tx_clk);
            check_equal(udp_tx_data, last_exp, "data held after a request past the packet");
            repeat ($urandom_range(8, 1)) @(posedge eth_tx_clk);
            udp_tx_done <= 1'b1;
            @(posedge eth_tx_clk);
            udp_tx_done <= 1'b0;
        end
    end

    task automatic wait_for_overflow();
        int cnt;
        cnt = 0;
        while (dropped < 4 && cnt < WAIT_LIMIT) begin
            @(posedge audio_clk);
            cnt++;
        end
        if (dropped < 4)
            report_timeout("the model to drop words on a full FIFO");
    endtask

    // all whole packets handed to the core
    task automatic wait_for_drain();
        int cnt;
        int target;
        cnt    = 0;
        target = (pushed / PKT_WORDS) * PKT_WORDS;
        while (captured < target && cnt < WAIT_LIMIT) begin
            @(posedge eth_tx_clk);
            cnt++;
        end
        if (captured < target)
            report_timeout("the buffered packets to drain");
    endtask

    task automatic wait_for_packet_close();
        int cnt;
        cnt = 0;
        while (in_pkt && cnt < WAIT_LIMIT) begin
            @(posedge eth_tx_clk);
            cnt++;
        end
        if (in_pkt)
            report_timeout("udp_tx_done of the last packet");
    endtask

    initial begin : main_flow
        void'($urandom(32'hf1a));
        repeat (2) @(posedge audio_clk);
        rst_n <= 1'b1;
        @(posedge audio_clk);
        check_equal(32'(udp_tx_start_en), 0, "udp_tx_start_en after reset");
        check_equal(32'(fifo_overflow), 0, "fifo_overflow after reset");
        check_equal(udp_tx_data, 0, "udp_tx_data after reset");

        stim_on = 1'b1;
        repeat (3000) @(posedge audio_clk);
        check_equal(32'(fifo_overflow), 0, "fifo_overflow under normal load");

        // starve the core until the FIFO overflows
        hold_req = 1'b1;
        stim_on  = 1'b0;
        repeat (50) @(posedge audio_clk);  // let in-flight pops settle
        stim_on = 1'b1;
        wait_for_overflow();
        stim_on = 1'b0;
        repeat (20) @(posedge audio_clk);
        hold_req = 1'b0;
        check_equal(32'(fifo_overflow), 1, "fifo_overflow after starving the core");
        wait_for_drain();

        stim_on = 1'b1;
        repeat (2000) @(posedge audio_clk);
        stim_on = 1'b0;
        repeat (20) @(posedge audio_clk);
        wait_for_drain();
        wait_for_packet_close();
        run_done = 1'b1;
        check_equal(packets, pushed / PKT_WORDS, "packet count after drain");
        check_equal(captured, packets * PKT_WORDS, "words captured after drain");

        $display("checks %0d, errors %0d, timeouts %0d, packets %0d, words %0d, dropped %0d",
                 checks, errors, timeouts, packets, captured, dropped);
        if (errors == 0 && timeouts == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- filelist.f
rtl/audio_pkt_pkg.sv
rtl/audio_sample_packer.sv
rtl/audio_async_fifo.sv
rtl/udp_pkt_scheduler.sv
rtl/audio_udp_tx_top.sv
sim/audio_udp_tx_checker.sv
sim/tb_audio_udp_tx.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, verdict from the log
rm -rf obj_dir sim.log build.log
verilator --binary --assert --timescale 1ns/1ps --top-module tb_audio_udp_tx \
    -f filelist.f -o tb_sim > build.log 2>&1 \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || echo "Regression failed" >> sim.log
cat sim.log
grep -q "Regression failed" sim.log && exit 1 || exit 0
